// ==== hdl/slave_agent_pkg.sv ====
// Slave agent package with the packet widths, field types, response codes and FIFO entries
package slave_agent_pkg;

   // ----------------------------------------------------------------------
   // widths
   // ----------------------------------------------------------------------

   // address and data widths as seen by the fabric and the slave
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // one byte enable per byte lane of the data word
   localparam int SYMBOLS = DATA_W / 8;
   localparam int BE_W = SYMBOLS;

   // low address bits that select a byte inside the word, cleared before the slave
   localparam int ADDR_LSB = $clog2(SYMBOLS);

   // source and destination ID fields of the packets
   localparam int ID_W = 3;

   // ----------------------------------------------------------------------
   // field types and response codes
   // ----------------------------------------------------------------------
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [BE_W-1:0]   be_t;
   typedef logic [ID_W-1:0]   id_t;
   typedef logic [1:0]        resp_t;

   // same encoding as the Avalon-MM response signal
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // ----------------------------------------------------------------------
   // packets, slave signals and FIFO entries
   // ----------------------------------------------------------------------

   // single-beat command packet from the fabric
   typedef struct packed {
      addr_t addr;
      data_t data;
      be_t   byteen;
      logic  read;
      logic  write;
      logic  posted;
      id_t   src_id;
      id_t   dest_id;
      logic  debug;
   } cmd_pkt_t;

   // response packet back to the fabric, IDs already swapped
   typedef struct packed {
      data_t data;
      resp_t status;
      logic  write;
      be_t   byteen;
      id_t   src_id;
      id_t   dest_id;
      logic  debug;
   } rsp_pkt_t;

   // Avalon-MM command side, driven towards the slave
   typedef struct packed {
      addr_t address;
      be_t   byteenable;
      logic  read;
      logic  write;
      data_t writedata;
      logic  debugaccess;
   } avm_cmd_t;

   // Avalon-MM return side, driven by the slave
   typedef struct packed {
      data_t readdata;
      logic  readdatavalid;
      resp_t response;
   } avm_rsp_t;

   // tracking entry, one per command that owes the fabric a response
   // synth marks entries whose response is made up without slave data
   typedef struct packed {
      logic synth;
      logic write;
      be_t  byteen;
      id_t  src_id;
      id_t  dest_id;
      logic debug;
   } track_entry_t;

   // read data and slave status captured from the return path
   typedef struct packed {
      data_t data;
      resp_t status;
   } rdata_entry_t;

endpackage

// ==== hdl/sync_fifo.sv ====
// Show-ahead synchronous FIFO built as a circular buffer, entry type set by parameter
`timescale 1ns/1ps

module sync_fifo #(
   parameter type entry_t = logic [7:0],
   parameter int  DEPTH   = 4
) (
   input  logic   clk,
   input  logic   reset,
   input  logic   push,
   input  entry_t din,
   input  logic   pop,
   output entry_t dout,
   output logic   full,
   output logic   empty
);

   // a single-entry FIFO still needs a one-bit pointer
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   entry_t           mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // pointers wrap at DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // storage holds payload only, so the write port is a plain clocked write
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // the count only moves when exactly one side is active
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   // head of queue is visible without a pop, one cycle after its push
   assign dout  = mem[rd_ptr];
   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   // the users gate their own push and pop with the flags
   a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
      else $error("push into a full FIFO");
   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
      else $error("pop from an empty FIFO");

endmodule

// ==== hdl/cmd_translator.sv ====
// Command translator that turns fabric command packets into Avalon-MM strobes and tracking entries
`timescale 1ns/1ps

module cmd_translator (
   input  logic                         cp_valid,
   input  slave_agent_pkg::cmd_pkt_t     cp,
   input  logic                         m0_waitrequest,
   input  logic                         track_full,
   output logic                         cp_ready,
   output slave_agent_pkg::avm_cmd_t     m0,
   output logic                         track_push,
   output slave_agent_pkg::track_entry_t track_entry
);

   import slave_agent_pkg::*;

   // clears the byte offset so the slave only sees word addresses
   localparam addr_t ADDR_MASK = ~addr_t'((1 << ADDR_LSB) - 1);

   logic suppress;
   logic issue;
   logic accept;
   logic needs_resp;

   // ----------------------------------------------------------------------
   // backpressure and suppression
   // ----------------------------------------------------------------------

   // a command with no byte lanes enabled never reaches the slave
   assign suppress = ~|cp.byteen;

   // a full tracking FIFO stalls every command, even posted writes
   // that would need no entry, which keeps the ready path short
   // suppressed commands do not wait for the slave
   assign cp_ready = ~track_full & (~m0_waitrequest | suppress);

   // the slave sees the strobe while it holds waitrequest, as the
   // Avalon-MM transfer completes only when waitrequest drops
   assign issue  = cp_valid & ~track_full & ~suppress;
   assign accept = cp_valid & cp_ready;

   // ----------------------------------------------------------------------
   // slave command
   // ----------------------------------------------------------------------
   always_comb begin
      m0.address     = cp.addr & ADDR_MASK;
      m0.byteenable  = cp.byteen;
      m0.writedata   = cp.data;
      m0.debugaccess = cp.debug;
      m0.read        = issue & cp.read;
      m0.write       = issue & cp.write;
   end

   // ----------------------------------------------------------------------
   // tracking entry
   // ----------------------------------------------------------------------

   // posted writes owe the fabric nothing, everything else gets an entry
   assign needs_resp = cp.read | (cp.write & ~cp.posted);
   assign track_push = accept & needs_resp;

   always_comb begin
      // suppressed reads and non-posted writes get a response made up
      // locally, since the slave never returns data for them
      track_entry.synth   = (cp.read & suppress) | (cp.write & ~cp.posted);
      track_entry.write   = cp.write;
      track_entry.byteen  = cp.byteen;
      track_entry.src_id  = cp.src_id;
      track_entry.dest_id = cp.dest_id;
      track_entry.debug   = cp.debug;
   end

   // the fabric must never send a packet flagged as both read and write
   always_comb begin
      assert final (!(m0.read && m0.write))
         else $error("read and write strobes raised together");
   end

endmodule

// ==== hdl/read_return_path.sv ====
// Read return path with a configurable latency stage ahead of the read-data FIFO
`timescale 1ns/1ps

module read_return_path #(
   parameter int READ_LATENCY = 2,
   parameter int FIFO_DEPTH   = 4
) (
   input  logic                          clk,
   input  logic                          reset,
   input  slave_agent_pkg::avm_rsp_t     m0_rsp,
   input  logic                          pop,
   output slave_agent_pkg::rdata_entry_t head,
   output logic                          empty
);

   import slave_agent_pkg::*;

   avm_rsp_t     rsp_dly;
   rdata_entry_t rdata_in;
   logic         full;

   // ----------------------------------------------------------------------
   // latency stage, stands in for the memory block versus ALM choice
   // ----------------------------------------------------------------------
   if (READ_LATENCY == 0) begin : g_no_delay
      assign rsp_dly = m0_rsp;
   end else begin : g_delay
      avm_rsp_t pipe_q [READ_LATENCY];

      // the valid bit travels with the data, so the whole chain is cleared
      always_ff @(posedge clk or posedge reset) begin
         if (reset) begin
            for (int i = 0; i < READ_LATENCY; i++) begin
               pipe_q[i] <= '0;
            end
         end else begin
            pipe_q[0] <= m0_rsp;
            for (int i = 1; i < READ_LATENCY; i++) begin
               pipe_q[i] <= pipe_q[i-1];
            end
         end
      end

      assign rsp_dly = pipe_q[READ_LATENCY-1];
   end

   // only data and status are kept, the valid bit becomes the push
   assign rdata_in.data   = rsp_dly.readdata;
   assign rdata_in.status = rsp_dly.response;

   // no ready towards the slave here, reads in flight are bounded by the
   // tracking FIFO, which has the same depth
   sync_fifo #(
      .entry_t (rdata_entry_t),
      .DEPTH   (FIFO_DEPTH)
   ) u_rdata_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (rsp_dly.readdatavalid),
      .din   (rdata_in),
      .pop   (pop),
      .dout  (head),
      .full  (full),
      .empty (empty)
   );

   // a data beat arriving at a full FIFO means a read was lost
   a_rdata_room: assert property (@(posedge clk) disable iff (reset)
      rsp_dly.readdatavalid |-> !full)
      else $error("slave returned more reads than were tracked");

endmodule

// ==== hdl/resp_assembler.sv ====
// Response assembler joining tracking entries with read data into response packets
`timescale 1ns/1ps

module resp_assembler (
   input  slave_agent_pkg::track_entry_t track_head,
   input  logic                          track_empty,
   input  slave_agent_pkg::rdata_entry_t rdata_head,
   input  logic                          rdata_empty,
   input  logic                          rp_ready,
   output logic                          track_pop,
   output logic                          rdata_pop,
   output logic                          rp_valid,
   output slave_agent_pkg::rsp_pkt_t     rp
);

   import slave_agent_pkg::*;

   logic xfer;

   // ----------------------------------------------------------------------
   // handshake
   // ----------------------------------------------------------------------

   // the oldest entry decides what is sent next, so responses keep
   // command order
   // a synthesized response needs no read data, all others wait for it
   assign rp_valid = ~track_empty & (track_head.synth | ~rdata_empty);
   assign xfer     = rp_valid & rp_ready;

   // both heads are show-ahead, so rp stays put until this pop
   assign track_pop = xfer;

   // synthesized responses leave the read data queued for the next read
   assign rdata_pop = xfer & ~track_head.synth;

   // ----------------------------------------------------------------------
   // packet fields
   // ----------------------------------------------------------------------
   always_comb begin
      if (track_head.synth) begin
         // suppressed read or non-posted write
         rp.data   = '0;
         rp.status = RESP_OKAY;
      end else begin
         rp.data   = rdata_head.data;
         rp.status = rdata_head.status;
      end

      // the response goes back to whoever sent the command
      rp.src_id  = track_head.dest_id;
      rp.dest_id = track_head.src_id;

      rp.write  = track_head.write;
      rp.byteen = track_head.byteen;
      rp.debug  = track_head.debug;
   end

endmodule

// ==== hdl/slave_agent.sv ====
// Slave agent top level, fabric command and response packets to an Avalon-MM slave
`timescale 1ns/1ps

module slave_agent #(
   parameter int FIFO_DEPTH   = 4,
   parameter int READ_LATENCY = 2
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      cp_valid,
   input  slave_agent_pkg::cmd_pkt_t cp,
   output logic                      cp_ready,
   output slave_agent_pkg::avm_cmd_t m0,
   input  logic                      m0_waitrequest,
   input  slave_agent_pkg::avm_rsp_t m0_rsp,
   output logic                      rp_valid,
   output slave_agent_pkg::rsp_pkt_t rp,
   input  logic                      rp_ready
);

   import slave_agent_pkg::*;

   // tracking FIFO, one entry per command that owes a response
   logic         track_push;
   track_entry_t track_entry;
   logic         track_full;
   logic         track_pop;
   track_entry_t track_head;
   logic         track_empty;

   // read-data FIFO head inside the return path
   rdata_entry_t rdata_head;
   logic         rdata_empty;
   logic         rdata_pop;

   // ----------------------------------------------------------------------
   // command side
   // ----------------------------------------------------------------------
   cmd_translator u_cmd_translator (
      .cp_valid       (cp_valid),
      .cp             (cp),
      .m0_waitrequest (m0_waitrequest),
      .track_full     (track_full),
      .cp_ready       (cp_ready),
      .m0             (m0),
      .track_push     (track_push),
      .track_entry    (track_entry)
   );

   sync_fifo #(
      .entry_t (track_entry_t),
      .DEPTH   (FIFO_DEPTH)
   ) u_track_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (track_push),
      .din   (track_entry),
      .pop   (track_pop),
      .dout  (track_head),
      .full  (track_full),
      .empty (track_empty)
   );

   // ----------------------------------------------------------------------
   // return side
   // ----------------------------------------------------------------------
   read_return_path #(
      .READ_LATENCY (READ_LATENCY),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) u_read_return_path (
      .clk    (clk),
      .reset  (reset),
      .m0_rsp (m0_rsp),
      .pop    (rdata_pop),
      .head   (rdata_head),
      .empty  (rdata_empty)
   );

   resp_assembler u_resp_assembler (
      .track_head  (track_head),
      .track_empty (track_empty),
      .rdata_head  (rdata_head),
      .rdata_empty (rdata_empty),
      .rp_ready    (rp_ready),
      .track_pop   (track_pop),
      .rdata_pop   (rdata_pop),
      .rp_valid    (rp_valid),
      .rp          (rp)
   );

endmodule

// ==== verif/mem_slave_model.sv ====
// Pipelined Avalon-MM memory slave with random waitrequest, one-cycle reads and an error region
`timescale 1ns/1ps

module mem_slave_model #(
   parameter int WORDS = 64
) (
   input  logic                      clk,
   input  logic                      reset,
   input  slave_agent_pkg::avm_cmd_t m0,
   output logic                      waitrequest,
   output slave_agent_pkg::avm_rsp_t rsp
);

   import slave_agent_pkg::*;

   localparam int IDX_W = $clog2(WORDS);

   data_t            mem [WORDS];
   avm_rsp_t         rsp_next;
   logic [IDX_W-1:0] idx;

   // word index from the masked address, the upper address bits alias onto it
   assign idx = m0.address[ADDR_LSB +: IDX_W];

   initial begin
      waitrequest = 1'b1;
      rsp         = '0;
   end

   // a transfer completes at the rising edge while waitrequest is low
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         // fill pattern is spread over every bit of the word index
         for (int i = 0; i < WORDS; i++) begin
            mem[i] <= (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
         end
         rsp_next <= '0;
      end else begin
         rsp_next <= '0;
         if (m0.read && !waitrequest) begin
            rsp_next.readdata      <= mem[idx];
            rsp_next.readdatavalid <= 1'b1;
            // the upper half of the address space answers with a slave error
            rsp_next.response      <= m0.address[15] ? RESP_SLVERR : RESP_OKAY;
         end
         if (m0.write && !waitrequest) begin
            for (int b = 0; b < BE_W; b++) begin
               if (m0.byteenable[b]) begin
                  mem[idx][8*b +: 8] <= m0.writedata[8*b +: 8];
               end
            end
         end
      end
   end

   // outputs change on the falling edge, so the agent samples them half a cycle later
   always @(negedge clk) begin
      if (reset) begin
         waitrequest <= 1'b1;
         rsp         <= '0;
      end else begin
         waitrequest <= ($urandom_range(3) == 0);
         rsp         <= rsp_next;
      end
   end

endmodule

// ==== verif/tb_slave_agent.sv ====
// Testbench for the slave agent, random commands checked against a shadow memory model
`timescale 1ns/1ps

module tb_slave_agent;

   import slave_agent_pkg::*;

   localparam int FIFO_DEPTH   = 4;
   localparam int READ_LATENCY = 2;
   localparam int WORDS        = 64;
   localparam int IDX_W        = $clog2(WORDS);
   localparam int NUM_CMDS     = 400;
   localparam int ACCEPT_LIMIT = 500;
   localparam int DRAIN_LIMIT  = 2000;

   logic     clk = 1'b0;
   logic     reset;
   logic     cp_valid;
   cmd_pkt_t cp;
   logic     cp_ready;
   avm_cmd_t m0;
   logic     m0_waitrequest;
   avm_rsp_t m0_rsp;
   logic     rp_valid;
   rsp_pkt_t rp;
   logic     rp_ready = 1'b0;

   // shadow of the slave memory and the responses still owed, oldest first
   data_t       shadow [WORDS];
   rsp_pkt_t    exp_q [$];
   rsp_pkt_t    exp_rsp;
   int          errors = 0;
   int          exp_count = 0;
   int          rsp_count = 0;
   int          full_stalls = 0;
   int          stall_left = 0;
   logic        draining = 1'b0;
   logic        timed_out = 1'b0;
   int unsigned seed_val;

   always #20 clk = ~clk;

   slave_agent #(
      .FIFO_DEPTH   (FIFO_DEPTH),
      .READ_LATENCY (READ_LATENCY)
   ) u_dut (
      .clk            (clk),
      .reset          (reset),
      .cp_valid       (cp_valid),
      .cp             (cp),
      .cp_ready       (cp_ready),
      .m0             (m0),
      .m0_waitrequest (m0_waitrequest),
      .m0_rsp         (m0_rsp),
      .rp_valid       (rp_valid),
      .rp             (rp),
      .rp_ready       (rp_ready)
   );

   mem_slave_model #(.WORDS(WORDS)) u_mem (
      .clk         (clk),
      .reset       (reset),
      .m0          (m0),
      .waitrequest (m0_waitrequest),
      .rsp         (m0_rsp)
   );

   // ----------------------------------------------------------------------
   // reference model
   // ----------------------------------------------------------------------
   function automatic data_t fill_word(input int idx);
      return (32'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
   endfunction

   // mix of reads, posted and non-posted writes, some with no byte lanes at all
   function automatic cmd_pkt_t random_command();
      cmd_pkt_t    c;
      int unsigned kind;
      c         = '0;
      kind      = $urandom_range(2);
      c.read    = (kind == 0);
      c.write   = (kind != 0);
      c.posted  = (kind == 1);
      c.addr    = addr_t'($urandom);
      c.data    = $urandom;
      c.byteen  = ($urandom_range(7) == 0) ? be_t'(0) : be_t'($urandom);
      c.src_id  = id_t'($urandom);
      c.dest_id = id_t'($urandom);
      c.debug   = 1'($urandom_range(1));
      return c;
   endfunction

   // applies an accepted command to the shadow memory and queues what it owes
   function automatic void record_accept(input cmd_pkt_t c);
      rsp_pkt_t e;
      int       idx;
      idx       = int'(c.addr[ADDR_LSB +: IDX_W]);
      e         = '0;
      e.write   = c.write;
      e.byteen  = c.byteen;
      e.src_id  = c.dest_id;
      e.dest_id = c.src_id;
      e.debug   = c.debug;
      if (c.read) begin
         // a read with no lanes enabled is answered locally with zero data
         if (c.byteen != '0) begin
            e.data   = shadow[idx];
            e.status = c.addr[15] ? RESP_SLVERR : RESP_OKAY;
         end
         exp_q.push_back(e);
         exp_count++;
      end else begin
         for (int b = 0; b < BE_W; b++) begin
            if (c.byteen[b]) begin
               shadow[idx][8*b +: 8] = c.data[8*b +: 8];
            end
         end
         if (!c.posted) begin
            exp_q.push_back(e);
            exp_count++;
         end
      end
   endfunction

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------
   task automatic send_command();
      int waited;
      @(negedge clk);
      cp       <= random_command();
      cp_valid <= 1'b1;
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
      end while (!cp_ready && waited < ACCEPT_LIMIT);
      if (cp_ready) begin
         record_accept(cp);
      end else begin
         errors++;
         timed_out = 1'b1;
         $display("timeout at %0t ns, command was never accepted", $time);
      end
   endtask

   task automatic wait_for_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         timed_out = 1'b1;
         $display("timeout at %0t ns, %0d responses never arrived", $time, exp_q.size());
      end
      // a few more cycles so that duplicate responses still get counted
      repeat (20) @(posedge clk);
   endtask

   // rp_ready toggles at random, with long low stretches to fill the FIFOs
   always @(negedge clk) begin
      if (draining) begin
         rp_ready <= 1'b1;
      end else if (stall_left > 0) begin
         rp_ready   <= 1'b0;
         stall_left <= stall_left - 1;
      end else if ($urandom_range(19) == 0) begin
         stall_left <= $urandom_range(40, 20);
      end else begin
         rp_ready <= ($urandom_range(3) != 0);
      end
   end

   // ----------------------------------------------------------------------
   // monitors
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      if (!reset) begin
         // ready held low with the slave free can only be the tracking FIFO
         if (cp_valid && !cp_ready && (!m0_waitrequest || cp.byteen == '0)) begin
            full_stalls++;
         end
         if ((m0.read || m0.write) && m0.byteenable == '0) begin
            errors++;
            $display("slave strobe at %0t ns for a command with no byte enables", $time);
         end
         // the slave sees the packet fields as sent, with the byte offset cleared
         if ((m0.read || m0.write) &&
             (m0.address != {cp.addr[ADDR_W-1:ADDR_LSB], {ADDR_LSB{1'b0}}} ||
              m0.byteenable != cp.byteen || m0.writedata != cp.data ||
              m0.debugaccess != cp.debug || m0.read != cp.read ||
              m0.write != cp.write)) begin
            errors++;
            $display("mismatch at %0t ns: slave command %h for packet %h", $time, m0, cp);
         end
         if (rp_valid && rp_ready) begin
            rsp_count++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("response at %0t ns arrived with no command waiting for it", $time);
            end else begin
               exp_rsp = exp_q.pop_front();
               if (rp != exp_rsp) begin
                  errors++;
                  $display("mismatch at %0t ns: response %h, expected %h", $time, rp,
                           exp_rsp);
               end
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin
      seed_val = $urandom(41);
      reset    = 1'b1;
      cp_valid = 1'b0;
      cp       = '0;
      for (int i = 0; i < WORDS; i++) begin
         shadow[i] = fill_word(i);
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset <= 1'b0;

      for (int n = 0; n < NUM_CMDS && !timed_out; n++) begin
         // an idle cycle now and then between commands
         if ($urandom_range(3) == 0) begin
            @(negedge clk);
            cp_valid <= 1'b0;
         end
         send_command();
      end
      @(negedge clk);
      cp_valid <= 1'b0;
      draining <= 1'b1;
      if (!timed_out) begin
         wait_for_drain();
      end

      if (rsp_count != exp_count) begin
         errors++;
         $display("mismatch at %0t ns: %0d responses, expected %0d", $time, rsp_count,
                  exp_count);
      end
      if (full_stalls == 0) begin
         errors++;
         $display("command ready never dropped for a full tracking FIFO");
      end
      $display("expected %0d, responses %0d, full stalls %0d, errors %0d", exp_count,
               rsp_count, full_stalls, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
hdl/slave_agent_pkg.sv
hdl/sync_fifo.sv
hdl/cmd_translator.sv
hdl/read_return_path.sv
hdl/resp_assembler.sv
hdl/slave_agent.sv
verif/mem_slave_model.sv
verif/tb_slave_agent.sv

// ==== run.sh ====
#!/bin/sh
# build the slave agent testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
   --top-module tb_slave_agent || exit 1
out="$(./obj_dir/Vtb_slave_agent)"
echo "$out"
echo "$out" | grep -q "All tests passed" && exit 0 || exit 1
